//--- rec_settings.svh
`ifndef REC_SETTINGS_SVH
`define REC_SETTINGS_SVH

// width of one stream word
`define REC_WORD_W 16

// largest legal payload length in words
`define REC_MAX_PAY 4

// header + payload + checksum, the longest record
`define REC_WIN_ELS 6

// storage slots in the shifting buffer
`define REC_BUF_ELS 8

// width of the record and checksum-error counters
`define REC_CNT_W 16

`endif

//--- rec_pkg.sv
`include "rec_settings.svh"

package rec_pkg;

  // one word of the input stream
  typedef logic [`REC_WORD_W-1:0] word_t;

  // payload length, taken from the low bits of a header
  typedef logic [2:0] len_t;

  // tag takes the rest of the header word
  typedef logic [`REC_WORD_W-4:0] tag_t;

  // words dropped from the buffer in one cycle, 0 up to a full window
  typedef logic [$clog2(`REC_WIN_ELS+1)-1:0] rel_cnt_t;

  // parallel view of the oldest buffered words
  // element 0 holds the oldest word
  typedef logic [`REC_WIN_ELS-1:0][`REC_WORD_W-1:0] win_t;

  // statistics counter, wraps on overflow
  typedef logic [`REC_CNT_W-1:0] cnt_t;

  // one assembled record as it leaves the packer
  // payload words past len read as zero
  typedef struct packed {
    tag_t                                      tag;
    len_t                                      len;
    logic [`REC_MAX_PAY-1:0][`REC_WORD_W-1:0] payload;
    logic                                      chk_ok;
  } rec_t;

endpackage

//--- sipo_buffer.sv
`timescale 1ns/1ps
`include "rec_settings.svh"

module sipo_buffer (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     valid_i,
  input  rec_pkg::word_t           data_i,
  output logic                     ready_o,
  output logic [`REC_WIN_ELS-1:0]  win_valid_o,
  output rec_pkg::win_t            win_data_o,
  input  rec_pkg::rel_cnt_t        rel_cnt_i
);

  localparam int ELS   = `REC_BUF_ELS;
  localparam int WIN   = `REC_WIN_ELS;
  localparam int CNT_W = $clog2(ELS + 1);

  // stored words, slot 0 is the oldest
  logic [ELS-1:0][`REC_WORD_W-1:0] data_r;
  logic [ELS-1:0]                  valid_r;
  logic [CNT_W-1:0]                num_els_r;

  // combined view of stored words plus the bypassed input
  // twice as deep so a shift never indexes past the end
  logic [2*ELS-1:0][`REC_WORD_W-1:0] data_n;
  logic [2*ELS-1:0]                  valid_n;

  // state after the release shift
  logic [ELS-1:0][`REC_WORD_W-1:0] data_nn;
  logic [ELS-1:0]                  valid_nn;
  logic [CNT_W-1:0]                num_els_n;

  logic accept;

  // room as long as the last slot is empty
  assign ready_o = ~valid_r[ELS-1];
  assign accept  = valid_i & ready_o;

  // occupancy after this cycle's write and release
  assign num_els_n = num_els_r + CNT_W'(accept) - CNT_W'(rel_cnt_i);

  always_comb begin
    data_n  = '0;
    valid_n = '0;
    data_n[ELS-1:0]  = data_r;
    valid_n[ELS-1:0] = valid_r;

    // new word lands at the fill position
    // so it is visible in the window this cycle
    data_n[num_els_r]  = data_i;
    valid_n[num_els_r] = accept;

    // drop the released words from the bottom
    for (int i = 0; i < ELS; i++) begin
      data_nn[i] = data_n[rel_cnt_i + i];
    end
    valid_nn = valid_n[rel_cnt_i +: ELS];
  end

  // window shows the oldest words before release
  assign win_valid_o = valid_n[WIN-1:0];
  assign win_data_o  = data_n[WIN-1:0];

  // control state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r   <= '0;
      num_els_r <= '0;
    end else begin
      valid_r   <= valid_nn;
      num_els_r <= num_els_n;
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    data_r <= data_nn;
  end

  // control must never take more words than the window holds
  a_rel_within_window : assert property (
    @(posedge clk_i) disable iff (reset_i)
    int'(rel_cnt_i) <= $countones(win_valid_o)
  ) else $error("sipo_buffer: release of %0d exceeds valid window", rel_cnt_i);

  // count register and valid vector stay in step
  a_count_matches_valid : assert property (
    @(posedge clk_i) disable iff (reset_i)
    int'(num_els_r) == $countones(valid_r)
  ) else $error("sipo_buffer: element count out of step with valid bits");

endmodule

//--- rec_checksum.sv
`timescale 1ns/1ps
`include "rec_settings.svh"

module rec_checksum (
  input  rec_pkg::win_t  win_data_i,
  input  rec_pkg::len_t  len_i,
  output logic           chk_ok_o
);

  // running sum of header and payload, modulo word width
  rec_pkg::word_t sum;
  // window position of the checksum word
  rec_pkg::len_t  chk_idx;

  always_comb begin
    // header always counts
    sum = win_data_i[0];
    // add only the payload words the header announces
    for (int i = 1; i <= `REC_MAX_PAY; i++) begin
      if (i <= int'(len_i)) begin
        sum = sum + win_data_i[i];
      end
    end
  end

  // clamp so an illegal length still indexes inside the window
  always_comb begin
    if (len_i > rec_pkg::len_t'(`REC_MAX_PAY)) begin
      chk_idx = rec_pkg::len_t'(`REC_MAX_PAY + 1);
    end else begin
      chk_idx = len_i + rec_pkg::len_t'(1);
    end
  end

  // checksum word follows the last payload word
  assign chk_ok_o = (sum == win_data_i[chk_idx]);

endmodule

//--- rec_packer.sv
`timescale 1ns/1ps
`include "rec_settings.svh"

module rec_packer (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           fire_i,
  input  rec_pkg::win_t  win_data_i,
  input  logic           chk_ok_i,
  output logic           rec_valid_o,
  output rec_pkg::rec_t  rec_o
);

  localparam int LEN_W = $bits(rec_pkg::len_t);
  localparam int TAG_W = $bits(rec_pkg::tag_t);

  rec_pkg::rec_t rec_n;
  rec_pkg::rec_t rec_r;
  logic          rec_valid_r;

  always_comb begin
    // header splits into tag on top and length below
    rec_n.tag = win_data_i[0][`REC_WORD_W-1 -: TAG_W];
    rec_n.len = win_data_i[0][LEN_W-1:0];

    // payload follows the header in the window
    // words beyond the length are forced to zero
    for (int i = 0; i < `REC_MAX_PAY; i++) begin
      if (i < int'(rec_n.len)) begin
        rec_n.payload[i] = win_data_i[i+1];
      end else begin
        rec_n.payload[i] = '0;
      end
    end

    rec_n.chk_ok = chk_ok_i;
  end

  // one-cycle strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rec_valid_r <= 1'b0;
    end else begin
      rec_valid_r <= fire_i;
    end
  end

  // record fields held until the next fire
  always_ff @(posedge clk_i) begin
    if (fire_i) begin
      rec_r <= rec_n;
    end
  end

  assign rec_valid_o = rec_valid_r;
  assign rec_o       = rec_r;

  // control only fires on a legal header length
  a_out_len_legal : assert property (
    @(posedge clk_i) disable iff (reset_i)
    rec_valid_o |-> (rec_o.len != '0) && (int'(rec_o.len) <= `REC_MAX_PAY)
  ) else $error("rec_packer: record out with illegal length %0d", rec_o.len);

endmodule

//--- rec_ctrl.sv
`timescale 1ns/1ps
`include "rec_settings.svh"

module rec_ctrl (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [`REC_WIN_ELS-1:0]  win_valid_i,
  input  rec_pkg::win_t            win_data_i,
  input  logic                     chk_ok_i,
  output rec_pkg::len_t            len_o,
  output rec_pkg::rel_cnt_t        rel_cnt_o,
  output logic                     fire_o,
  output logic                     frame_err_o,
  output rec_pkg::cnt_t            rec_cnt_o,
  output rec_pkg::cnt_t            chk_err_cnt_o
);

  localparam int LEN_W = $bits(rec_pkg::len_t);

  rec_pkg::len_t     len;
  logic              len_legal;
  logic              drop;
  logic              fire;
  rec_pkg::rel_cnt_t rel_cnt;

  logic              frame_err_r;
  rec_pkg::cnt_t     rec_cnt_r;
  rec_pkg::cnt_t     chk_err_cnt_r;

  // window element 0 is taken as the header
  assign len       = win_data_i[0][LEN_W-1:0];
  assign len_legal = (len != '0) && (int'(len) <= `REC_MAX_PAY);

  // release rule, decided from the window alone
  always_comb begin
    rel_cnt = '0;
    fire    = 1'b0;
    drop    = 1'b0;
    if (win_valid_i[0]) begin
      if (!len_legal) begin
        // bad header, discard just that word
        rel_cnt = rec_pkg::rel_cnt_t'(1);
        drop    = 1'b1;
      end else if (win_valid_i[len + 1]) begin
        // checksum word present so the record is whole
        rel_cnt = rec_pkg::rel_cnt_t'(len) + rec_pkg::rel_cnt_t'(2);
        fire    = 1'b1;
      end
      // otherwise wait for more words
    end
  end

  // framing error strobe lines up with the packer output
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      frame_err_r <= 1'b0;
    end else begin
      frame_err_r <= drop;
    end
  end

  // statistics, both wrap
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rec_cnt_r     <= '0;
      chk_err_cnt_r <= '0;
    end else if (fire) begin
      rec_cnt_r <= rec_cnt_r + rec_pkg::cnt_t'(1);
      if (!chk_ok_i) begin
        chk_err_cnt_r <= chk_err_cnt_r + rec_pkg::cnt_t'(1);
      end
    end
  end

  assign len_o         = len;
  assign rel_cnt_o     = rel_cnt;
  assign fire_o        = fire;
  assign frame_err_o   = frame_err_r;
  assign rec_cnt_o     = rec_cnt_r;
  assign chk_err_cnt_o = chk_err_cnt_r;

  // valid window words form one unbroken run from element 0
  // so a valid checksum slot means the whole record is there
  a_win_contig : assert property (
    @(posedge clk_i) disable iff (reset_i)
    ((win_valid_i + 1'b1) & win_valid_i) == '0
  ) else $error("rec_ctrl: gap in window valid bits %b", win_valid_i);

endmodule

//--- rec_assembler_top.sv
`timescale 1ns/1ps
`include "rec_settings.svh"

module rec_assembler_top (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           valid_i,
  input  rec_pkg::word_t data_i,
  output logic           ready_o,
  output logic           rec_valid_o,
  output rec_pkg::rec_t  rec_o,
  output logic           frame_err_o,
  output rec_pkg::cnt_t  rec_cnt_o,
  output rec_pkg::cnt_t  chk_err_cnt_o
);

  // window from the buffer
  logic [`REC_WIN_ELS-1:0] win_valid;
  rec_pkg::win_t           win_data;

  // control back to buffer and packer
  rec_pkg::rel_cnt_t rel_cnt;
  rec_pkg::len_t     len;
  logic              rec_fire;

  // checksum verdict
  logic chk_ok;

  sipo_buffer sipo_buffer_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .data_i      (data_i),
    .ready_o     (ready_o),
    .win_valid_o (win_valid),
    .win_data_o  (win_data),
    .rel_cnt_i   (rel_cnt)
  );

  rec_ctrl rec_ctrl_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .win_valid_i   (win_valid),
    .win_data_i    (win_data),
    .chk_ok_i      (chk_ok),
    .len_o         (len),
    .rel_cnt_o     (rel_cnt),
    .fire_o        (rec_fire),
    .frame_err_o   (frame_err_o),
    .rec_cnt_o     (rec_cnt_o),
    .chk_err_cnt_o (chk_err_cnt_o)
  );

  rec_checksum rec_checksum_i (
    .win_data_i (win_data),
    .len_i      (len),
    .chk_ok_o   (chk_ok)
  );

  rec_packer rec_packer_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fire_i      (rec_fire),
    .win_data_i  (win_data),
    .chk_ok_i    (chk_ok),
    .rec_valid_o (rec_valid_o),
    .rec_o       (rec_o)
  );

endmodule

//--- tb_rec_assembler.sv
`timescale 1ns/1ps
`include "rec_settings.svh"

module tb_rec_assembler;

  localparam int ACC_TIMEOUT   = 100;
  localparam int DRAIN_TIMEOUT = 400;
  localparam int TAIL_CYCLES   = 10;

  logic                 clk_i;
  logic                 reset_i;
  logic                 valid_i;
  rec_pkg::word_t       data_i;
  logic                 ready_o;
  logic                 rec_valid_o;
  rec_pkg::rec_t        rec_o;
  logic                 frame_err_o;
  rec_pkg::cnt_t        rec_cnt_o;
  rec_pkg::cnt_t        chk_err_cnt_o;

  // sent words and the idle cycles before each one
  rec_pkg::word_t stream_q[$];
  int             gap_q[$];
  // expected records and the stream index of their last word
  rec_pkg::rec_t  exp_q[$];
  int             exp_last_q[$];
  // stream index of every header that must be dropped
  int             ferr_last_q[$];
  // cycle number of the edge that accepted each word
  int             acc_cyc_q[$];

  // illegal header lengths
  int bad_lens[4] = '{0, 5, 6, 7};

  int n_corrupt;
  int n_ferr_exp;
  int cyc;
  int rec_seen;
  int ferr_seen;
  int val_errs;
  int other_errs;
  int timeouts;
  bit ok;

  rec_assembler_top rec_assembler_top_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .valid_i       (valid_i),
    .data_i        (data_i),
    .ready_o       (ready_o),
    .rec_valid_o   (rec_valid_o),
    .rec_o         (rec_o),
    .frame_err_o   (frame_err_o),
    .rec_cnt_o     (rec_cnt_o),
    .chk_err_cnt_o (chk_err_cnt_o)
  );

  always #4 clk_i = ~clk_i;

  // expected records straight from the framing rule
  // returns the number of framing errors
  function automatic int parse_stream(input rec_pkg::word_t words[$]);
    int             pos;
    int             len;
    int             n_ferr;
    rec_pkg::word_t sum;
    rec_pkg::rec_t  r;
    pos    = 0;
    n_ferr = 0;
    while (pos < words.size()) begin
      len = int'(words[pos][2:0]);
      if (len < 1 || len > `REC_MAX_PAY) begin
        // one bad header word goes, the next word is a header
        ferr_last_q.push_back(pos);
        n_ferr++;
        pos++;
      end else if (pos + len + 1 < words.size()) begin
        r         = '0;
        r.tag     = words[pos][15:3];
        r.len     = rec_pkg::len_t'(len);
        sum       = words[pos];
        for (int i = 0; i < len; i++) begin
          r.payload[i] = words[pos + 1 + i];
          sum          = sum + words[pos + 1 + i];
        end
        r.chk_ok = (sum == words[pos + len + 1]);
        exp_q.push_back(r);
        exp_last_q.push_back(pos + len + 1);
        pos = pos + len + 2;
      end else begin
        // incomplete tail never completes
        break;
      end
    end
    return n_ferr;
  endfunction

  task automatic push_word(input rec_pkg::word_t w, input int gap_max);
    stream_q.push_back(w);
    gap_q.push_back((gap_max == 0) ? 0 : int'($urandom_range(gap_max, 0)));
  endtask

  // header, payload and checksum, optionally with a broken checksum
  task automatic add_record(input int len, input bit corrupt, input int gap_max);
    rec_pkg::word_t hdr;
    rec_pkg::word_t w;
    rec_pkg::word_t sum;
    hdr = {rec_pkg::tag_t'($urandom), rec_pkg::len_t'(len)};
    sum = hdr;
    push_word(hdr, gap_max);
    for (int i = 0; i < len; i++) begin
      w   = rec_pkg::word_t'($urandom);
      sum = sum + w;
      push_word(w, gap_max);
    end
    if (corrupt) begin
      sum = sum + rec_pkg::word_t'($urandom_range(16'hffff, 1));
      n_corrupt++;
    end
    push_word(sum, gap_max);
  endtask

  // lone header word with a length outside 1 to 4
  task automatic add_bad_header(input int len, input int gap_max);
    push_word({rec_pkg::tag_t'($urandom), rec_pkg::len_t'(len)}, gap_max);
  endtask

  task automatic build_stream();
    int kind;
    int bad;
    // back-to-back clean records of every length
    for (int l = 1; l <= `REC_MAX_PAY; l++) add_record(l, 1'b0, 0);
    // every corrupt length once, no gaps
    for (int l = 1; l <= `REC_MAX_PAY; l++) add_record(l, 1'b1, 0);
    // each illegal length, each followed by a good record
    foreach (bad_lens[i]) begin
      add_bad_header(bad_lens[i], 1);
      add_record(int'($urandom_range(`REC_MAX_PAY, 1)), 1'b0, 1);
    end
    // random mix with idle gaps
    for (int i = 0; i < 40; i++) begin
      kind = int'($urandom_range(9, 0));
      if (kind < 2) begin
        bad = int'($urandom_range(3, 0));
        add_bad_header((bad == 0) ? 0 : bad + 4, 3);
      end else begin
        add_record(int'($urandom_range(`REC_MAX_PAY, 1)), kind < 4, 3);
      end
    end
  endtask

  // one word per acceptance, never more than one outstanding
  task automatic drive_stream(output bit done_ok);
    int wait_cnt;
    done_ok = 1'b1;
    for (int i = 0; i < stream_q.size(); i++) begin
      if (gap_q[i] > 0) begin
        valid_i <= 1'b0;
        repeat (gap_q[i]) @(posedge clk_i);
      end
      valid_i  <= 1'b1;
      data_i   <= stream_q[i];
      wait_cnt = 0;
      do begin
        @(posedge clk_i);
        wait_cnt++;
      end while (!ready_o && wait_cnt < ACC_TIMEOUT);
      if (!ready_o) begin
        $display("ERROR: word %0d was never accepted, ready_o stayed low", i);
        timeouts++;
        valid_i <= 1'b0;
        done_ok = 1'b0;
        return;
      end
    end
    valid_i <= 1'b0;
  endtask

  // output monitor, sampled at the rising edge
  always @(posedge clk_i) begin
    if (rec_valid_o) begin
      if (rec_seen >= exp_q.size()) begin
        $display("ERROR: record strobe with no record expected at %0t", $time);
        other_errs++;
      end else begin
        if (rec_o !== exp_q[rec_seen]) begin
          $display("FAIL rec_o: got %h expected %h", rec_o, exp_q[rec_seen]);
          val_errs++;
        end
        // strobe belongs one cycle after the checksum word edge
        if (exp_last_q[rec_seen] >= acc_cyc_q.size() ||
            cyc != acc_cyc_q[exp_last_q[rec_seen]] + 1) begin
          $display("ERROR: record %0d came out at the wrong cycle", rec_seen);
          other_errs++;
        end
      end
      rec_seen++;
    end
    if (frame_err_o) begin
      if (ferr_seen >= ferr_last_q.size()) begin
        $display("ERROR: framing error strobe with none expected at %0t", $time);
        other_errs++;
      end else if (ferr_last_q[ferr_seen] >= acc_cyc_q.size() ||
                   cyc != acc_cyc_q[ferr_last_q[ferr_seen]] + 1) begin
        $display("ERROR: framing error %0d came out at the wrong cycle", ferr_seen);
        other_errs++;
      end
      ferr_seen++;
    end
    if (valid_i && ready_o) begin
      acc_cyc_q.push_back(cyc);
    end
    cyc++;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  initial begin
    int wait_cnt;
    clk_i   = 1'b0;
    reset_i = 1'b1;
    valid_i = 1'b0;
    data_i  = '0;
    void'($urandom(40));
    build_stream();
    n_ferr_exp = parse_stream(stream_q);
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // idle outputs straight after reset
    @(negedge clk_i);
    check_value("rec_valid_o", rec_valid_o, 0);
    check_value("frame_err_o", frame_err_o, 0);
    check_value("rec_cnt_o", rec_cnt_o, 0);
    check_value("chk_err_cnt_o", chk_err_cnt_o, 0);
    check_value("ready_o", ready_o, 1);

    @(posedge clk_i);
    drive_stream(ok);
    if (ok) begin
      // wait until every expected strobe has shown up
      wait_cnt = 0;
      while ((rec_seen < exp_q.size() || ferr_seen < n_ferr_exp) &&
             wait_cnt < DRAIN_TIMEOUT) begin
        @(negedge clk_i);
        wait_cnt++;
      end
      if (rec_seen < exp_q.size() || ferr_seen < n_ferr_exp) begin
        $display("ERROR: output strobes still missing after the stream drained");
        timeouts++;
      end
      // late extra strobes would be counted here
      repeat (TAIL_CYCLES) @(negedge clk_i);
      check_value("rec_cnt_o", rec_cnt_o, exp_q.size());
      check_value("chk_err_cnt_o", chk_err_cnt_o, n_corrupt);
      check_value("frame_err_o count", ferr_seen, n_ferr_exp);
      check_value("rec_valid_o count", rec_seen, exp_q.size());
    end

    $display("errors: value %0d, other %0d, timeout %0d (records %0d, framing %0d)",
             val_errs, other_errs, timeouts, exp_q.size(), n_ferr_exp);
    if (val_errs == 0 && other_errs == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
rec_pkg.sv
sipo_buffer.sv
rec_checksum.sv
rec_packer.sv
rec_ctrl.sv
rec_assembler_top.sv
tb_rec_assembler.sv

//--- Bender.yml
package:
  name: rec_assembler

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rec_pkg.sv
      - sipo_buffer.sv
      - rec_checksum.sv
      - rec_packer.sv
      - rec_ctrl.sv
      - rec_assembler_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rec_assembler.sv
